// File: run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_spim_bridge -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
	exit 0
else
	exit 1
fi

// File: spim_bridge_top.sv
////////////////////////////////////////////////////////////////////////////
// register and buffer block of the SPI master, single clock domain
// no wait-request; host strobes are one cycle and never overlap
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module spim_bridge_top (
	input  wire logic                            m_avmm_clk,
	input  wire logic                            m_avmm_rst_n,
	input  wire spim_map_pkg::avmm_req_t         avmm_req,
	output logic [spim_map_pkg::DATA_W-1:0]      avbreg_rdata,
	output logic                                 avbreg_rdatavld,
	input  wire spim_buf_pkg::spi_req_t          spi_req,
	output logic [spim_map_pkg::DATA_W-1:0]      mosi_data,
	output logic                                 mosi_vld,
	input  wire logic                            trans_done,
	input  wire logic                            ssn_off,
	input  wire logic [spim_map_pkg::DATA_W-1:0] dbg_bus0,
	input  wire logic [spim_map_pkg::DATA_W-1:0] dbg_bus1,
	output logic                                 s_transvld,
	output spim_map_pkg::spim_cmd_t              spim_cmd
);

	logic                            wbuf_push;
	logic [spim_map_pkg::DATA_W-1:0] wbuf_wdata;
	logic                            wbuf_sfrst;
	spim_buf_pkg::buf_stat_t         wbuf_stat;

	logic                            rbuf_pop;
	logic                            rbuf_sfrst;
	logic [spim_map_pkg::DATA_W-1:0] rbuf_rdata;
	spim_buf_pkg::buf_stat_t         rbuf_stat;

	logic [spim_map_pkg::DATA_W-1:0] cmd_word;
	logic                            auto_dis;
	logic                            auto_flush;

	spim_csr u_csr (
		.m_avmm_clk   (m_avmm_clk),
		.m_avmm_rst_n (m_avmm_rst_n),
		.avmm_req     (avmm_req),
		.rdata        (avbreg_rdata),
		.rdatavld     (avbreg_rdatavld),
		.trans_done   (trans_done),
		.ssn_off      (ssn_off),
		.dbg_bus0     (dbg_bus0),
		.dbg_bus1     (dbg_bus1),
		.wbuf_push    (wbuf_push),
		.wbuf_wdata   (wbuf_wdata),
		.wbuf_sfrst   (wbuf_sfrst),
		.wbuf_stat    (wbuf_stat),
		.rbuf_pop     (rbuf_pop),
		.rbuf_sfrst   (rbuf_sfrst),
		.rbuf_rdata   (rbuf_rdata),
		.rbuf_stat    (rbuf_stat),
		.cmd_word     (cmd_word),
		.auto_dis     (auto_dis),
		.auto_flush   (auto_flush)
	);

	// host fills, SPI side drains
	spim_buf_fifo u_wbuf (
		.m_avmm_clk   (m_avmm_clk),
		.m_avmm_rst_n (m_avmm_rst_n),
		.push         (wbuf_push),
		.wdata        (wbuf_wdata),
		.pop          (spi_req.wbuf_pop),
		.sfrst        (wbuf_sfrst),
		.rdata        (mosi_data),
		.rvld         (mosi_vld),
		.stat         (wbuf_stat)
	);

	// SPI side fills, host drains; csr tracks its own read valid
	spim_buf_fifo u_rbuf (
		.m_avmm_clk   (m_avmm_clk),
		.m_avmm_rst_n (m_avmm_rst_n),
		.push         (spi_req.rbuf_push),
		.wdata        (spi_req.miso_data),
		.pop          (rbuf_pop),
		.sfrst        (rbuf_sfrst),
		.rdata        (rbuf_rdata),
		.rvld         (),
		.stat         (rbuf_stat)
	);

	spim_cmd_launch u_launch (
		.m_avmm_clk   (m_avmm_clk),
		.m_avmm_rst_n (m_avmm_rst_n),
		.cmd_word     (cmd_word),
		.auto_dis     (auto_dis),
		.s_transvld   (s_transvld),
		.spim_cmd     (spim_cmd),
		.auto_flush   (auto_flush)
	);

endmodule

`default_nettype wire

// File: spim_buf_fifo.sv
////////////////////////////////////////////////////////////////////////////
// single clock buffer, no back-pressure; a push when full is dropped
// soft reset empties the buffer and wins over a push or pop in that cycle
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module spim_buf_fifo (
	input  wire logic                            m_avmm_clk,
	input  wire logic                            m_avmm_rst_n,
	input  wire logic                            push,
	input  wire logic [spim_map_pkg::DATA_W-1:0] wdata,
	input  wire logic                            pop,
	input  wire logic                            sfrst,
	output logic [spim_map_pkg::DATA_W-1:0]      rdata,
	output logic                                 rvld,
	output spim_buf_pkg::buf_stat_t              stat
);

	logic [spim_map_pkg::DATA_W-1:0]    mem [spim_buf_pkg::BUF_DEPTH];
	logic [spim_buf_pkg::BUF_PTR_W-1:0] wr_ptr;
	logic [spim_buf_pkg::BUF_PTR_W-1:0] rd_ptr;
	logic [spim_buf_pkg::BUF_CNT_W-1:0] count;
	logic                               ovf_q;
	logic                               unf_q;
	logic                               full;
	logic                               empty;
	logic                               do_push;
	logic                               do_pop;

	assign full    = (count == spim_buf_pkg::BUF_FULL_CNT);
	assign empty   = (count == '0);
	assign do_push = push && !full && !sfrst;
	assign do_pop  = pop && !empty && !sfrst;

	always_ff @(posedge m_avmm_clk) begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

	//////////////////////////////////////////////////////////////////////////
	// pointers and fill count
	//////////////////////////////////////////////////////////////////////////

	always_ff @(posedge m_avmm_clk or negedge m_avmm_rst_n) begin
		if (!m_avmm_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (sfrst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + spim_buf_pkg::BUF_PTR_ONE;
			if (do_pop)
				rd_ptr <= rd_ptr + spim_buf_pkg::BUF_PTR_ONE;
			case ({do_push, do_pop})
			2'b10:   count <= count + spim_buf_pkg::BUF_CNT_ONE;
			2'b01:   count <= count - spim_buf_pkg::BUF_CNT_ONE;
			default: count <= count;  // idle, or push and pop together
			endcase
		end
	end

	// sticky error flags
	always_ff @(posedge m_avmm_clk or negedge m_avmm_rst_n) begin
		if (!m_avmm_rst_n) begin
			ovf_q <= 1'b0;
			unf_q <= 1'b0;
		end else if (sfrst) begin
			ovf_q <= 1'b0;
			unf_q <= 1'b0;
		end else begin
			if (push && full)
				ovf_q <= 1'b1;
			if (pop && empty)
				unf_q <= 1'b1;
		end
	end

	// head word, zero when nothing was there to pop
	always_ff @(posedge m_avmm_clk or negedge m_avmm_rst_n) begin
		if (!m_avmm_rst_n) begin
			rdata <= '0;
			rvld  <= 1'b0;
		end else begin
			rvld  <= pop;
			rdata <= do_pop ? mem[rd_ptr] : '0;
		end
	end

	assign stat.count = count;
	assign stat.ovf   = ovf_q;
	assign stat.unf   = unf_q;

	a_cnt_max: assert property (@(posedge m_avmm_clk) disable iff (!m_avmm_rst_n)
		count <= spim_buf_pkg::BUF_FULL_CNT);

endmodule

`default_nettype wire

// File: spim_buf_pkg.sv
////////////////////////////////////////////////////////////////////////////
// buffer sizing and status word layout, count is 0..BUF_DEPTH inclusive
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package spim_buf_pkg;

	localparam int BUF_DEPTH = 64;
	localparam int BUF_PTR_W = 6;
	localparam int BUF_CNT_W = 7;

	localparam logic [BUF_CNT_W-1:0] BUF_FULL_CNT = 7'd64;
	localparam logic [BUF_CNT_W-1:0] BUF_CNT_ONE  = 7'd1;
	localparam logic [BUF_PTR_W-1:0] BUF_PTR_ONE  = 6'd1;

	// status word bit positions
	localparam int STAT_WBUF_OVF = 0;
	localparam int STAT_WBUF_UNF = 1;
	localparam int STAT_RBUF_OVF = 2;
	localparam int STAT_RBUF_UNF = 3;
	localparam int STAT_WCNT_LSB = 8;
	localparam int STAT_RCNT_LSB = 16;

	typedef struct packed {
		logic [BUF_CNT_W-1:0] count;
		logic                 ovf;   // push while full, sticky
		logic                 unf;   // pop while empty, sticky
	} buf_stat_t;

	typedef struct packed {
		logic                            wbuf_pop;
		logic                            rbuf_push;
		logic [spim_map_pkg::DATA_W-1:0] miso_data;
	} spi_req_t;

	function automatic logic [spim_map_pkg::DATA_W-1:0] pack_status(input buf_stat_t ws,
		input buf_stat_t rs);
		logic [spim_map_pkg::DATA_W-1:0] word;
		word = '0;
		word[STAT_WBUF_OVF] = ws.ovf;
		word[STAT_WBUF_UNF] = ws.unf;
		word[STAT_RBUF_OVF] = rs.ovf;
		word[STAT_RBUF_UNF] = rs.unf;
		word[STAT_WCNT_LSB +: BUF_CNT_W] = ws.count;
		word[STAT_RCNT_LSB +: BUF_CNT_W] = rs.count;
		return word;
	endfunction

endpackage

`default_nettype wire

// File: spim_cmd_launch.sv
////////////////////////////////////////////////////////////////////////////
// command launcher, one cycle from the command register to s_transvld
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module spim_cmd_launch (
	input  wire logic                            m_avmm_clk,
	input  wire logic                            m_avmm_rst_n,
	input  wire logic [spim_map_pkg::DATA_W-1:0] cmd_word,
	input  wire logic                            auto_dis,
	output logic                                 s_transvld,
	output spim_map_pkg::spim_cmd_t              spim_cmd,
	output logic                                 auto_flush
);

	spim_map_pkg::launch_state_e state;
	spim_map_pkg::spim_cmd_t     cmd_fields;
	logic                        cmd_vld;

	assign cmd_vld            = cmd_word[spim_map_pkg::CMD_VLD_BIT];
	assign cmd_fields.sselect = cmd_word[spim_map_pkg::CMD_SSEL_MSB:spim_map_pkg::CMD_SSEL_LSB];
	assign cmd_fields.brstlen = cmd_word[spim_map_pkg::CMD_BRST_MSB:spim_map_pkg::CMD_BRST_LSB];
	assign cmd_fields.rdnwr   = cmd_word[spim_map_pkg::CMD_RDNWR_BIT];

	always_ff @(posedge m_avmm_clk or negedge m_avmm_rst_n) begin
		if (!m_avmm_rst_n) begin
			state      <= spim_map_pkg::LAUNCH_IDLE;
			s_transvld <= 1'b0;
			spim_cmd   <= '0;
			auto_flush <= 1'b0;
		end else begin
			auto_flush <= 1'b0;
			case (state)
			spim_map_pkg::LAUNCH_IDLE: begin
				if (cmd_vld) begin
					state      <= spim_map_pkg::LAUNCH_ACTIVE;
					s_transvld <= 1'b1;
					spim_cmd   <= cmd_fields;  // held for the whole transaction
					auto_flush <= !auto_dis;
				end
			end
			spim_map_pkg::LAUNCH_ACTIVE: begin
				if (!cmd_vld) begin        // trans_done or host cleared the bit
					state      <= spim_map_pkg::LAUNCH_IDLE;
					s_transvld <= 1'b0;
				end
			end
			endcase
		end
	end

	a_vld_state: assert property (@(posedge m_avmm_clk) disable iff (!m_avmm_rst_n)
		s_transvld == (state == spim_map_pkg::LAUNCH_ACTIVE));

endmodule

`default_nettype wire

// File: spim_csr.sv
////////////////////////////////////////////////////////////////////////////
// host register file and window decode, read data one cycle after strobe
// buffer strobes are decoded combinationally from the host request
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module spim_csr (
	input  wire logic                            m_avmm_clk,
	input  wire logic                            m_avmm_rst_n,
	input  wire spim_map_pkg::avmm_req_t         avmm_req,
	output logic [spim_map_pkg::DATA_W-1:0]      rdata,
	output logic                                 rdatavld,
	input  wire logic                            trans_done,
	input  wire logic                            ssn_off,
	input  wire logic [spim_map_pkg::DATA_W-1:0] dbg_bus0,
	input  wire logic [spim_map_pkg::DATA_W-1:0] dbg_bus1,
	output logic                                 wbuf_push,
	output logic [spim_map_pkg::DATA_W-1:0]      wbuf_wdata,
	output logic                                 wbuf_sfrst,
	input  wire spim_buf_pkg::buf_stat_t         wbuf_stat,
	output logic                                 rbuf_pop,
	output logic                                 rbuf_sfrst,
	input  wire logic [spim_map_pkg::DATA_W-1:0] rbuf_rdata,
	input  wire spim_buf_pkg::buf_stat_t         rbuf_stat,
	output logic [spim_map_pkg::DATA_W-1:0]      cmd_word,
	output logic                                 auto_dis,
	input  wire logic                            auto_flush
);

	logic                            in_wbuf;
	logic                            in_rbuf;
	logic                            sfrst_wr;
	logic [spim_map_pkg::DATA_W-1:0] cmd_q;
	logic [spim_map_pkg::DATA_W-1:0] diag0_q;
	logic [spim_map_pkg::DATA_W-1:0] diag1_q;
	logic [spim_map_pkg::DATA_W-1:0] rdata_q;
	logic [spim_map_pkg::DATA_W-1:0] reg_rd;
	logic                            sel_buf;   // last read came from the read buffer
	logic                            wbuf_sfrst_q;
	logic                            rbuf_sfrst_q;

	//////////////////////////////////////////////////////////////////////////
	// address decode
	//////////////////////////////////////////////////////////////////////////

	assign in_wbuf = (avmm_req.addr >= spim_map_pkg::WBUF_LO) &&
		(avmm_req.addr <= spim_map_pkg::WBUF_HI);
	assign in_rbuf = (avmm_req.addr >= spim_map_pkg::RBUF_LO) &&
		(avmm_req.addr <= spim_map_pkg::RBUF_HI);

	assign wbuf_push  = avmm_req.wr && in_wbuf;
	assign wbuf_wdata = avmm_req.wdata;
	assign rbuf_pop   = avmm_req.rd && in_rbuf;
	assign sfrst_wr   = avmm_req.wr && (avmm_req.addr == spim_map_pkg::ADDR_SFRST);

	//////////////////////////////////////////////////////////////////////////
	// registers
	//////////////////////////////////////////////////////////////////////////

	always_ff @(posedge m_avmm_clk or negedge m_avmm_rst_n) begin
		if (!m_avmm_rst_n) begin
			cmd_q <= '0;
		end else if (avmm_req.wr && (avmm_req.addr == spim_map_pkg::ADDR_CMD)) begin
			cmd_q <= avmm_req.wdata;
		end else if (trans_done) begin
			cmd_q[spim_map_pkg::CMD_VLD_BIT] <= 1'b0; // transaction finished
		end
	end

	always_ff @(posedge m_avmm_clk or negedge m_avmm_rst_n) begin
		if (!m_avmm_rst_n) begin
			diag0_q <= '0;
			diag1_q <= '0;
		end else begin
			if (ssn_off && !trans_done)
				diag0_q <= dbg_bus0;  // snapshot at slave deselect
			diag1_q <= dbg_bus1;      // free running copy
		end
	end

	// soft reset pulses and the auto-flush disable level
	always_ff @(posedge m_avmm_clk or negedge m_avmm_rst_n) begin
		if (!m_avmm_rst_n) begin
			wbuf_sfrst_q <= 1'b0;
			rbuf_sfrst_q <= 1'b0;
			auto_dis     <= 1'b0;
		end else begin
			wbuf_sfrst_q <= sfrst_wr && avmm_req.wdata[spim_map_pkg::SFRST_WBUF];
			rbuf_sfrst_q <= sfrst_wr && avmm_req.wdata[spim_map_pkg::SFRST_RBUF];
			if (sfrst_wr)
				auto_dis <= avmm_req.wdata[spim_map_pkg::SFRST_AUTO_DIS];
		end
	end

	assign wbuf_sfrst = wbuf_sfrst_q;
	assign rbuf_sfrst = rbuf_sfrst_q || auto_flush; // flush at every launch
	assign cmd_word   = cmd_q;

	//////////////////////////////////////////////////////////////////////////
	// read path
	//////////////////////////////////////////////////////////////////////////

	always_comb begin
		reg_rd = '0;
		case (avmm_req.addr)
		spim_map_pkg::ADDR_CMD:    reg_rd = cmd_q;
		spim_map_pkg::ADDR_STATUS: reg_rd = spim_buf_pkg::pack_status(wbuf_stat, rbuf_stat);
		spim_map_pkg::ADDR_DIAG0:  reg_rd = diag0_q;
		spim_map_pkg::ADDR_DIAG1:  reg_rd = diag1_q;
		spim_map_pkg::ADDR_SFRST:  reg_rd[spim_map_pkg::SFRST_AUTO_DIS] = auto_dis;
		default:                   reg_rd = '0;
		endcase
	end

	always_ff @(posedge m_avmm_clk or negedge m_avmm_rst_n) begin
		if (!m_avmm_rst_n) begin
			rdata_q  <= '0;
			sel_buf  <= 1'b0;
			rdatavld <= 1'b0;
		end else begin
			rdatavld <= avmm_req.rd;
			if (avmm_req.rd) begin
				sel_buf <= in_rbuf;
				rdata_q <= reg_rd;
			end
		end
	end

	// buffer head word is already registered inside the buffer
	assign rdata = sel_buf ? rbuf_rdata : rdata_q;

	a_no_rd_wr: assert property (@(posedge m_avmm_clk) disable iff (!m_avmm_rst_n)
		!(avmm_req.rd && avmm_req.wr));

endmodule

`default_nettype wire

// File: spim_map_pkg.sv
////////////////////////////////////////////////////////////////////////////
// host side map of the SPI master register block, 16-bit byte addresses
// command bit 0 is the valid bit, other command bits are latched on launch
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package spim_map_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 32;

	// register offsets
	localparam logic [ADDR_W-1:0] ADDR_CMD    = 16'h0000;
	localparam logic [ADDR_W-1:0] ADDR_STATUS = 16'h0004;
	localparam logic [ADDR_W-1:0] ADDR_DIAG0  = 16'h0008;
	localparam logic [ADDR_W-1:0] ADDR_DIAG1  = 16'h000C;
	localparam logic [ADDR_W-1:0] ADDR_SFRST  = 16'h0010;

	// buffer windows, bounds inclusive
	localparam logic [ADDR_W-1:0] WBUF_LO = 16'h0200;
	localparam logic [ADDR_W-1:0] WBUF_HI = 16'h09FF;
	localparam logic [ADDR_W-1:0] RBUF_LO = 16'h1000;
	localparam logic [ADDR_W-1:0] RBUF_HI = 16'h17FF;

	// command word layout
	localparam int CMD_VLD_BIT   = 0;
	localparam int CMD_RDNWR_BIT = 1;
	localparam int CMD_BRST_LSB  = 2;
	localparam int CMD_BRST_MSB  = 15;
	localparam int CMD_SSEL_LSB  = 30;
	localparam int CMD_SSEL_MSB  = 31;

	// soft reset register bits
	localparam int SFRST_WBUF     = 0;
	localparam int SFRST_RBUF     = 1;
	localparam int SFRST_AUTO_DIS = 2; // level, stored

	typedef struct packed {
		logic              wr;     // one cycle strobe
		logic              rd;     // one cycle strobe
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} avmm_req_t;

	typedef struct packed {
		logic [1:0]  sselect;
		logic [13:0] brstlen;
		logic        rdnwr;
	} spim_cmd_t;

	typedef enum logic {
		LAUNCH_IDLE,
		LAUNCH_ACTIVE
	} launch_state_e;

endpackage

`default_nettype wire

// File: tb.f
spim_map_pkg.sv
spim_buf_pkg.sv
spim_buf_fifo.sv
spim_cmd_launch.sv
spim_csr.sv
spim_bridge_top.sv
tb_spim_bridge.sv

// File: tb_spim_bridge.sv
////////////////////////////////////////////////////////////////////////////
// self-checking testbench for spim_bridge_top, xorshift stimulus
// the model keeps both buffers, stickies, command and diag registers
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_spim_bridge;

	localparam int N_WORDS = 16;
	localparam int N_DIAG  = 8;
	localparam int TEST_CYCLES = 8 * N_WORDS + 8 * (spim_buf_pkg::BUF_DEPTH + 1) + 80 +
		12 * N_DIAG;
	localparam longint WATCHDOG_NS = longint'(TEST_CYCLES) * 100 + 50000;

	logic                    m_avmm_clk;
	logic                    m_avmm_rst_n;
	spim_map_pkg::avmm_req_t avmm_req;
	logic [31:0]             avbreg_rdata;
	logic                    avbreg_rdatavld;
	spim_buf_pkg::spi_req_t  spi_req;
	logic [31:0]             mosi_data;
	logic                    mosi_vld;
	logic                    trans_done;
	logic                    ssn_off;
	logic [31:0]             dbg_bus0;
	logic [31:0]             dbg_bus1;
	logic                    s_transvld;
	spim_map_pkg::spim_cmd_t spim_cmd;

	logic [31:0] wq[$];   // write buffer model
	logic [31:0] rq[$];   // read buffer model
	logic        w_ovf;
	logic        w_unf;
	logic        r_ovf;
	logic        r_unf;
	logic        auto_dis_m;
	logic [31:0] diag0_m;
	logic [31:0] rng;
	int          err_cnt;
	int          test_err;
	int          n_tests;
	int          n_checks;

	spim_bridge_top u_dut (.*);

	always #50 m_avmm_clk = ~m_avmm_clk;

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// model and compare helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		rng ^= rng << 13;
		rng ^= rng >> 17;
		rng ^= rng << 5;
		return rng;
	endfunction

	// random byte offset inside a 2 KB buffer window
	function automatic logic [15:0] rand_offset();
		logic [31:0] r;
		r = next_rand();
		return {5'b0, r[10:0]};
	endfunction

	function automatic logic [31:0] exp_status();
		logic [31:0] s;
		s = '0;
		s[0] = w_ovf;
		s[1] = w_unf;
		s[2] = r_ovf;
		s[3] = r_unf;
		s[14:8]  = 7'(wq.size());
		s[22:16] = 7'(rq.size());
		return s;
	endfunction

	function automatic spim_map_pkg::spim_cmd_t cmd_fields(input logic [31:0] c);
		spim_map_pkg::spim_cmd_t f;
		f.sselect = c[31:30];
		f.brstlen = c[15:2];
		f.rdnwr   = c[1];
		return f;
	endfunction

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			$display("ERR %s got %h exp %h", name, got, exp);
			err_cnt++;
			test_err++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			$display("ERR %s got %h exp %h", name, got, exp);
			err_cnt++;
			test_err++;
		end
	endtask

	task automatic check_cmd(input spim_map_pkg::spim_cmd_t got,
		input spim_map_pkg::spim_cmd_t exp);
		n_checks++;
		if (got !== exp) begin
			$display("ERR spim_cmd got %h exp %h", got, exp);
			err_cnt++;
			test_err++;
		end
	endtask

	task automatic end_test(input string name);
		n_tests++;
		$display("%s: %s, %0d errors", name, (test_err == 0) ? "ok" : "failed", test_err);
		test_err = 0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// bus tasks, drive on the rising edge and sample on the falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic host_write(input logic [15:0] addr, input logic [31:0] data);
		@(posedge m_avmm_clk);
		avmm_req <= '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
		@(posedge m_avmm_clk);
		avmm_req.wr <= 1'b0;
	endtask

	task automatic read_check(input string name, input logic [15:0] addr,
		input logic [31:0] exp);
		@(posedge m_avmm_clk);
		avmm_req.rd   <= 1'b1;
		avmm_req.addr <= addr;
		@(posedge m_avmm_clk);
		avmm_req.rd <= 1'b0;
		@(negedge m_avmm_clk);
		check_bit("avbreg_rdatavld", avbreg_rdatavld, 1'b1);
		check_word(name, avbreg_rdata, exp);
	endtask

	task automatic wbuf_write(input logic [15:0] addr, input logic [31:0] data);
		host_write(addr, data);
		if (wq.size() == spim_buf_pkg::BUF_DEPTH)
			w_ovf = 1'b1;
		else
			wq.push_back(data);
	endtask

	task automatic wbuf_pop_check();
		logic [31:0] exp;
		exp = '0;
		if (wq.size() == 0)
			w_unf = 1'b1;
		else
			exp = wq.pop_front();
		@(posedge m_avmm_clk);
		spi_req.wbuf_pop <= 1'b1;
		@(posedge m_avmm_clk);
		spi_req.wbuf_pop <= 1'b0;
		@(negedge m_avmm_clk);
		check_bit("mosi_vld", mosi_vld, 1'b1);
		check_word("mosi_data", mosi_data, exp);
	endtask

	task automatic rbuf_push_word(input logic [31:0] data);
		@(posedge m_avmm_clk);
		spi_req <= '{wbuf_pop: 1'b0, rbuf_push: 1'b1, miso_data: data};
		@(posedge m_avmm_clk);
		spi_req.rbuf_push <= 1'b0;
		if (rq.size() == spim_buf_pkg::BUF_DEPTH)
			r_ovf = 1'b1;
		else
			rq.push_back(data);
	endtask

	task automatic rbuf_read_check();
		logic [31:0] exp;
		logic [15:0] addr;
		exp = '0;
		if (rq.size() == 0)
			r_unf = 1'b1;
		else
			exp = rq.pop_front();
		addr = spim_map_pkg::RBUF_LO + rand_offset();
		read_check("avbreg_rdata", addr, exp);
	endtask

	task automatic sfrst_write(input logic [31:0] data);
		host_write(spim_map_pkg::ADDR_SFRST, data);
		if (data[0]) begin
			wq.delete();
			w_ovf = 1'b0;
			w_unf = 1'b0;
		end
		if (data[1]) begin
			rq.delete();
			r_ovf = 1'b0;
			r_unf = 1'b0;
		end
		auto_dis_m = data[2];
	endtask

	// command write, then transaction valid two cycles after the strobe
	task automatic launch_check(input logic [31:0] cmd);
		host_write(spim_map_pkg::ADDR_CMD, cmd);
		@(negedge m_avmm_clk);
		check_bit("s_transvld", s_transvld, 1'b0);
		@(negedge m_avmm_clk);
		check_bit("s_transvld", s_transvld, 1'b1);
		check_cmd(spim_cmd, cmd_fields(cmd));
		if (!auto_dis_m) begin     // launch flushes the read buffer
			rq.delete();
			r_ovf = 1'b0;
			r_unf = 1'b0;
		end
	endtask

	task automatic expect_fall();
		@(negedge m_avmm_clk);
		check_bit("s_transvld", s_transvld, 1'b1);
		@(negedge m_avmm_clk);
		check_bit("s_transvld", s_transvld, 1'b0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] cmd;
		logic [31:0] d0;
		logic [31:0] d1;
		logic [15:0] waddr;
		m_avmm_clk = 1'b0;
		m_avmm_rst_n = 1'b0;
		avmm_req = '0;
		spi_req = '0;
		trans_done = 1'b0;
		ssn_off = 1'b0;
		dbg_bus0 = '0;
		dbg_bus1 = '0;
		rng = 32'h7959_a1ef;
		{w_ovf, w_unf, r_ovf, r_unf, auto_dis_m} = '0;
		diag0_m = '0;
		{err_cnt, test_err, n_tests, n_checks} = '0;
		repeat (4) @(posedge m_avmm_clk);
		m_avmm_rst_n <= 1'b1;

		for (int i = 0; i < N_WORDS; i++) begin
			waddr = spim_map_pkg::WBUF_LO + rand_offset();
			wbuf_write(waddr, next_rand());
		end
		for (int i = 0; i < N_WORDS; i++)
			wbuf_pop_check();
		end_test("write buffer path");

		for (int i = 0; i < N_WORDS; i++)
			rbuf_push_word(next_rand());
		for (int i = 0; i <= N_WORDS; i++)
			rbuf_read_check();     // last one hits the empty buffer
		end_test("read buffer path");

		for (int i = 0; i <= spim_buf_pkg::BUF_DEPTH; i++)
			wbuf_write(spim_map_pkg::WBUF_HI, next_rand());
		read_check("avbreg_rdata(status)", spim_map_pkg::ADDR_STATUS, exp_status());
		sfrst_write(32'h1);
		read_check("avbreg_rdata(status)", spim_map_pkg::ADDR_STATUS, exp_status());
		wbuf_pop_check();
		for (int i = 0; i <= spim_buf_pkg::BUF_DEPTH; i++)
			rbuf_push_word(next_rand());
		read_check("avbreg_rdata(status)", spim_map_pkg::ADDR_STATUS, exp_status());
		sfrst_write(32'h2);
		read_check("avbreg_rdata(status)", spim_map_pkg::ADDR_STATUS, exp_status());
		sfrst_write(32'h1);
		read_check("avbreg_rdata(status)", spim_map_pkg::ADDR_STATUS, 32'h0);
		end_test("error flags");

		cmd = next_rand() | 32'h1;
		launch_check(cmd);
		@(posedge m_avmm_clk);
		trans_done <= 1'b1;
		@(posedge m_avmm_clk);
		trans_done <= 1'b0;
		expect_fall();
		read_check("avbreg_rdata(cmd)", spim_map_pkg::ADDR_CMD, cmd & ~32'h1);
		end_test("command launch");

		for (int i = 0; i < N_WORDS / 2; i++)
			rbuf_push_word(next_rand());
		launch_check(next_rand() | 32'h1);
		read_check("avbreg_rdata(status)", spim_map_pkg::ADDR_STATUS, exp_status());
		host_write(spim_map_pkg::ADDR_CMD, next_rand() & ~32'h1);   // host ends it
		expect_fall();
		sfrst_write(32'h4);
		read_check("avbreg_rdata(sfrst)", spim_map_pkg::ADDR_SFRST, 32'h4);
		for (int i = 0; i < N_WORDS / 2; i++)
			rbuf_push_word(next_rand());
		launch_check(next_rand() | 32'h1);
		read_check("avbreg_rdata(status)", spim_map_pkg::ADDR_STATUS, exp_status());
		for (int i = 0; i < N_WORDS / 2; i++)
			rbuf_read_check();
		end_test("auto flush");

		for (int i = 0; i < N_DIAG; i++) begin
			d0 = next_rand();
			d1 = next_rand();
			@(posedge m_avmm_clk);
			dbg_bus0   <= d0;
			dbg_bus1   <= d1;
			ssn_off    <= i[0];
			trans_done <= i[1];       // all four strobe pairs come up
			if (i[0] && !i[1])
				diag0_m = d0;
			@(posedge m_avmm_clk);
			ssn_off    <= 1'b0;
			trans_done <= 1'b0;
			read_check("avbreg_rdata(diag0)", spim_map_pkg::ADDR_DIAG0, diag0_m);
			read_check("avbreg_rdata(diag1)", spim_map_pkg::ADDR_DIAG1, d1);
		end
		end_test("diagnostics");

		$display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, err_cnt);
		if (err_cnt == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
